//--- Makefile
VERILATOR ?= verilator
TOP       ?= mem_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/mem_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker for the memory controller testbench: samples DUT outputs,
// compares them and keeps the check and error counts
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_checker (
    input  logic                                clock,
    input  mem_pkg::word_t                      bus_rdata,
    input  mem_pkg::word_t                      gfx_pal_bg_data,
    input  mem_pkg::word_t                      gfx_pal_obj_data,
    input  logic [15:0]                         int_acks,
    input  mem_pkg::word_t                      fifo_val,
    input  logic [mem_pkg::FIFO_LEVEL_BITS-1:0] fifo_level
);
    import mem_pkg::*;

    int checks = 0;
    int errors = 0;

    task automatic compare_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (act === exp) begin
            $display("ok %s %08h", name, act);
        end else begin
            errors++;
            $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("ERROR %s", msg);
    endtask

    // Address driven in this cycle, data sampled mid next cycle
    task automatic read_data_check(input string name, input word_t exp);
        @(posedge clock);
        @(negedge clock);
        compare_value(name, exp, bus_rdata);
    endtask

    task automatic gfx_data_check(input string name, input bit obj, input word_t exp);
        @(posedge clock);
        @(negedge clock);
        compare_value(name, exp, obj ? gfx_pal_obj_data : gfx_pal_bg_data);
    endtask

    // Side outputs are checked in the current cycle
    task automatic side_check(input string name, input byte kind, input word_t exp);
        word_t act;
        @(negedge clock);
        case (kind)
            "V":     act = fifo_val;
            "L":     act = word_t'(fifo_level);
            "A":     act = word_t'(int_acks);
            default: act = '0;
        endcase
        compare_value(name, exp, act);
    endtask

    task automatic print_counts();
        $display("checks %0d, errors %0d", checks, errors);
    endtask

endmodule

//--- bench/mem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory controller testbench: clock, reset, data file steps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_tb;
    import mem_pkg::*;

    logic                       clock;
    logic                       reset;
    word_t                      bus_addr;
    word_t                      bus_wdata;
    mem_size_t                  bus_size;
    logic                       bus_write;
    word_t                      bus_rdata;
    logic                       bus_pause;
    word_t                      gfx_pal_bg_addr;
    word_t                      gfx_pal_obj_addr;
    word_t                      gfx_pal_bg_data;
    word_t                      gfx_pal_obj_data;
    logic [15:0]                buttons;
    logic [15:0]                reg_if;
    logic [15:0]                int_acks;
    logic                       fifo_re;
    logic                       fifo_clr;
    word_t                      fifo_val;
    logic [FIFO_LEVEL_BITS-1:0] fifo_level;

    // Set when a step ends 1 ns after an edge, ready for the next drive
    logic in_cycle;
    logic aborted;
    int   wait_limit = 16;

    mem_top i_mem_top (.*);

    mem_checker i_checker (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Write in cycle N, pause in N+1, write lands at the end of N+1
    task automatic bus_write_access(input string name, input word_t a, input int sz,
                                    input word_t d);
        int cycles;
        bus_addr  = a;
        bus_size  = mem_size_t'(sz);
        bus_wdata = d;
        bus_write = 1'b1;
        cycles    = 0;
        do begin
            @(posedge clock);
            #1;
            bus_write = 1'b0;
            cycles++;
        end while (!bus_pause && cycles < wait_limit);
        if (!bus_pause) begin
            i_checker.note_failure($sformatf("timeout, bus_pause never rose in %s", name));
            aborted = 1'b1;
        end else begin
            i_checker.compare_value({name, ".pause_delay"}, 1, cycles);
            cycles = 0;
            do begin
                @(posedge clock);
                #1;
                cycles++;
            end while (bus_pause && cycles < wait_limit);
            if (bus_pause) begin
                i_checker.note_failure($sformatf("timeout, bus_pause stuck high in %s", name));
                aborted = 1'b1;
            end else begin
                i_checker.compare_value({name, ".pause_len"}, 1, cycles);
                in_cycle = 1'b1;
            end
        end
    endtask

    task automatic bus_read_access(input string name, input word_t a, input int sz,
                                   input word_t exp);
        bus_addr  = a;
        bus_size  = mem_size_t'(sz);
        bus_write = 1'b0;
        i_checker.read_data_check(name, exp);
    endtask

    task automatic gfx_read(input string name, input word_t a, input bit obj,
                            input word_t exp);
        if (obj) begin
            gfx_pal_obj_addr = a;
        end else begin
            gfx_pal_bg_addr = a;
        end
        i_checker.gfx_data_check(name, obj, exp);
    endtask

    // One-cycle pop or clear strobe
    task automatic fifo_strobe(input bit pop);
        if (pop) begin
            fifo_re = 1'b1;
        end else begin
            fifo_clr = 1'b1;
        end
        @(posedge clock);
        #1;
        fifo_re  = 1'b0;
        fifo_clr = 1'b0;
        in_cycle = 1'b1;
    endtask

    initial begin
        int    fd;
        int    fields;
        int    size_col;
        string line;
        string op;
        string name;
        byte   opc;
        word_t addr;
        word_t wdata;
        word_t exp;

        reset            = 1'b1;
        bus_addr         = '0;
        bus_wdata        = '0;
        bus_size         = SIZE_WORD;
        bus_write        = 1'b0;
        gfx_pal_bg_addr  = '0;
        gfx_pal_obj_addr = '0;
        buttons          = '0;
        reg_if           = '0;
        fifo_re          = 1'b0;
        fifo_clr         = 1'b0;
        in_cycle         = 1'b0;
        aborted          = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;

        fd = $fopen("bench/mem_testdata.txt", "r");
        if (fd == 0) begin
            i_checker.note_failure("could not open bench/mem_testdata.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                line = "";
            end
            if (line.len() >= 2 && line[0] != "#") begin
                fields = $sscanf(line, "%s %h %h %h %h %s", op, addr, size_col, wdata, exp,
                                 name);
                opc = op[0];
                if (fields != 6) begin
                    i_checker.note_failure({"badly formed data line: ", line});
                end else begin
                    if (!in_cycle) begin
                        @(posedge clock);
                        #1;
                    end
                    in_cycle = 1'b0;
                    case (opc)
                        "W":     bus_write_access(name, addr, size_col, wdata);
                        "R":     bus_read_access(name, addr, size_col, exp);
                        "G":     gfx_read(name, addr, size_col[0], exp);
                        "B":     buttons = wdata[15:0];
                        "I":     reg_if = wdata[15:0];
                        "P":     fifo_strobe(1'b1);
                        "C":     fifo_strobe(1'b0);
                        "V", "L", "A": i_checker.side_check(name, opc, exp);
                        default: i_checker.note_failure({"unknown operation in step ", name});
                    endcase
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        i_checker.print_counts();
        if (i_checker.errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- bench/mem_testdata.txt
# op addr size wdata expect name (hex; size 0 byte, 1 half, 2 word; G size 0 bg, 1 obj)
# op: W write, R read, G gfx read, B buttons, I reg_if, P pop, C clear, V/L/A side checks
W 03000010 2 11223344 00000000 work_word
W 03000011 0 0000AB00 00000000 work_byte1
W 03000012 1 CDEF0000 00000000 work_half_hi
R 03000010 2 00000000 CDEFAB44 work_merged
W 03000020 2 DEADBEEF 00000000 work_second
R 03000020 2 00000000 DEADBEEF work_second_rd
R 03000010 2 00000000 CDEFAB44 work_still
W 05000008 2 12345678 00000000 pal_bg_wr
W 05000208 2 9ABCDEF0 00000000 pal_obj_wr
R 05000008 2 00000000 12345678 pal_bg_rd
R 05000208 2 00000000 9ABCDEF0 pal_obj_rd
G 05000008 0 00000000 12345678 gfx_bg
G 05000208 1 00000000 9ABCDEF0 gfx_obj
W 04000000 2 A5A50F0F 00000000 dispcnt_wr
R 04000000 2 00000000 A5A50F0F dispcnt_rd
W 04000003 0 3C000000 00000000 dispcnt_byte3
R 04000000 2 00000000 3CA50F0F dispcnt_merged
B 00000000 0 000003FF 00000000 buttons_set
R 04000130 2 00000000 000003FF keyinput_rd
W 04000130 2 12345678 00000000 keyinput_wr
R 04000130 2 00000000 123403FF keyinput_merged
I 00000000 0 00000081 00000000 reg_if_set
W 04000200 1 00003FFF 00000000 ie_wr
R 04000200 2 00000000 00813FFF ie_if_rd
W 04000202 1 00050000 00000000 iack_wr
A 00000000 0 00000000 00000005 iack_pulse
A 00000000 0 00000000 00000000 iack_cleared
R 04000200 2 00000000 00813FFF ie_kept
R 04000100 2 00000000 00000000 io_unmapped
R 06000000 2 00000000 00000000 region_unmapped
L 00000000 0 00000000 00000000 fifo_empty
W 040000A0 2 00000011 00000000 fifo_push0
W 040000A0 2 00000022 00000000 fifo_push1
W 040000A0 2 00000033 00000000 fifo_push2
W 040000A0 2 00000044 00000000 fifo_push3
W 040000A0 2 00000055 00000000 fifo_push4
W 040000A0 2 00000066 00000000 fifo_push5
W 040000A0 2 00000077 00000000 fifo_push6
W 040000A0 2 00000088 00000000 fifo_push7
W 040000A0 2 00000099 00000000 fifo_push_full
L 00000000 0 00000000 00000008 fifo_full
V 00000000 0 00000000 00000011 fifo_head0
R 040000A0 2 00000000 00000011 fifo_read_port
P 00000000 0 00000000 00000000 fifo_pop0
V 00000000 0 00000000 00000022 fifo_head1
P 00000000 0 00000000 00000000 fifo_pop1
V 00000000 0 00000000 00000033 fifo_head2
L 00000000 0 00000000 00000006 fifo_level6
C 00000000 0 00000000 00000000 fifo_clear
L 00000000 0 00000000 00000000 fifo_cleared

//--- files.f
src/mem_pkg.sv
src/mem_bus_if.sv
src/bus_control.sv
src/work_ram.sv
src/palette_ram.sv
src/io_regs.sv
src/sound_fifo.sv
src/mem_top.sv
bench/mem_checker.sv
bench/mem_tb.sv

//--- src/bus_control.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus control: write latch and pause, region and lane decode,
// read data select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module bus_control (
    input  logic                clock,
    input  logic                reset,
    input  mem_pkg::word_t      bus_addr,
    input  mem_pkg::word_t      bus_wdata,
    input  mem_pkg::mem_size_t  bus_size,
    input  logic                bus_write,
    output logic                bus_pause,
    output mem_pkg::word_t      bus_rdata,
    mem_bus_if.ctrl             mem
);
    import mem_pkg::*;

    word_t     addr_lat;
    mem_size_t size_lat;
    logic      write_lat;
    region_t   region;
    lanes_t    lanes;

    // One register stage; a write seen during pause is dropped
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            addr_lat  <= '0;
            size_lat  <= SIZE_BYTE;
            write_lat <= 1'b0;
        end else begin
            addr_lat  <= bus_addr;
            size_lat  <= bus_size;
            write_lat <= bus_write & ~bus_pause;
        end
    end

    assign bus_pause = write_lat;

    always_comb begin
        case (addr_lat[31:24])
            REGION_WORK: region = REG_WORK;
            REGION_PAL:  region = REG_PAL;
            REGION_IO:   region = REG_IO;
            default:     region = REG_NONE;
        endcase
    end

    // Size and low address bits give the byte lanes
    always_comb begin
        lanes = '0;
        if (write_lat) begin
            case (size_lat)
                SIZE_BYTE: lanes = lanes_t'(4'b0001 << addr_lat[1:0]);
                SIZE_HALF: lanes = addr_lat[1] ? 4'b1100 : 4'b0011;
                SIZE_WORD: lanes = 4'b1111;
                default:   lanes = '0;
            endcase
        end
    end

    assign mem.mem_addr = write_lat ? addr_lat : bus_addr;
    assign mem.addr_lat = addr_lat;
    assign mem.wdata    = bus_wdata;
    assign mem.we_work  = (region == REG_WORK) ? lanes : '0;
    assign mem.we_pal   = (region == REG_PAL)  ? lanes : '0;
    assign mem.we_io    = (region == REG_IO)   ? lanes : '0;

    always_comb begin
        case (region)
            REG_WORK: bus_rdata = mem.rd_work;
            REG_PAL:  bus_rdata = mem.rd_pal;
            REG_IO:   bus_rdata = mem.rd_io;
            default:  bus_rdata = '0;
        endcase
    end

    // Lanes only fire in the pause cycle that follows a requested write
    a_lane_in_pause: assert property (@(posedge clock) disable iff (reset)
        (|(mem.we_work | mem.we_pal | mem.we_io)) |-> bus_pause && $past(bus_write));

    // Requester holds address and size through the pause cycle
    a_hold_in_pause: assert property (@(posedge clock) disable iff (reset)
        bus_pause |-> (bus_addr == addr_lat) && (bus_size == size_lat));

endmodule

//--- src/io_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I/O registers: DISPCNT, KEYINPUT, IE/IF/IACK and sound FIFO port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module io_regs (
    input  logic           clock,
    input  logic           reset,
    mem_bus_if.io          mem,
    input  logic [15:0]    buttons,
    input  logic [15:0]    reg_if,
    output logic [15:0]    int_acks,
    output logic           fifo_push,
    input  mem_pkg::word_t fifo_head
);
    import mem_pkg::*;

    logic [11:0] word_off;
    word_t       dispcnt;
    logic [15:0] key_high;
    logic [15:0] ie;
    lanes_t      wr_dispcnt;
    lanes_t      wr_key;
    lanes_t      wr_ie_if;
    lanes_t      wr_fifo;

    assign word_off   = {mem.addr_lat[11:2], 2'b00};
    assign wr_dispcnt = (word_off == IO_DISPCNT)  ? mem.we_io : '0;
    assign wr_key     = (word_off == IO_KEYINPUT) ? mem.we_io : '0;
    assign wr_ie_if   = (word_off == IO_IE_IF)    ? mem.we_io : '0;
    assign wr_fifo    = (word_off == IO_FIFO_A)   ? mem.we_io : '0;

    // Only the low lane pushes a sample
    assign fifo_push = wr_fifo[0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dispcnt  <= '0;
            key_high <= '0;
            ie       <= '0;
            int_acks <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_dispcnt[i]) begin
                    dispcnt[8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
            for (int i = 0; i < 2; i++) begin
                if (wr_key[i+2]) begin
                    key_high[8*i +: 8] <= mem.wdata[16+8*i +: 8];
                end
                if (wr_ie_if[i]) begin
                    ie[8*i +: 8] <= mem.wdata[8*i +: 8];
                end
                // IACK lives one cycle, a fresh write wins over the clear
                int_acks[8*i +: 8] <= wr_ie_if[i+2] ? mem.wdata[16+8*i +: 8] : 8'h00;
            end
        end
    end

    always_comb begin
        case (word_off)
            IO_DISPCNT:  mem.rd_io = dispcnt;
            IO_KEYINPUT: mem.rd_io = {key_high, buttons};
            IO_IE_IF:    mem.rd_io = {reg_if, ie};
            IO_FIFO_A:   mem.rd_io = fifo_head;
            default:     mem.rd_io = '0;
        endcase
    end

endmodule

//--- src/mem_bus_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decoded bus traffic between the control block and the memories
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface mem_bus_if;
    import mem_pkg::*;

    // Latched address during a write, live address otherwise
    word_t  mem_addr;
    word_t  addr_lat;
    word_t  wdata;
    // Byte lanes, already gated by region
    lanes_t we_work;
    lanes_t we_pal;
    lanes_t we_io;
    word_t  rd_work;
    word_t  rd_pal;
    word_t  rd_io;

    modport ctrl (output mem_addr, addr_lat, wdata, we_work, we_pal, we_io,
                  input  rd_work, rd_pal, rd_io);
    modport work (input mem_addr, wdata, we_work, output rd_work);
    modport pal  (input mem_addr, addr_lat, wdata, we_pal, output rd_pal);
    modport io   (input addr_lat, wdata, we_io, output rd_io);

endinterface

//--- src/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory controller package: address map, widths, RAM sizes,
// I/O offsets and the access size and region enums
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  lanes_t;

    // Access size as sent by the CPU
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    typedef enum logic [1:0] {
        REG_NONE  = 2'd0,
        REG_WORK  = 2'd1,
        REG_PAL   = 2'd2,
        REG_IO    = 2'd3
    } region_t;

    // Top address byte of each area
    localparam logic [7:0] REGION_WORK = 8'h03;
    localparam logic [7:0] REGION_IO   = 8'h04;
    localparam logic [7:0] REGION_PAL  = 8'h05;

    localparam int WORK_WORDS_LOG2 = 13;
    localparam int PAL_WORDS_LOG2  = 7;

    // Object palette starts here, so this bit picks the bank
    localparam logic [31:0] PAL_OBJ_OFFSET = 32'h0000_0200;
    localparam int          PAL_BANK_BIT   = $clog2(PAL_OBJ_OFFSET);

    // Offsets inside the I/O area
    localparam logic [11:0] IO_DISPCNT  = 12'h000;
    localparam logic [11:0] IO_FIFO_A   = 12'h0A0;
    localparam logic [11:0] IO_KEYINPUT = 12'h130;
    localparam logic [11:0] IO_IE_IF    = 12'h200;

    localparam int FIFO_DEPTH      = 8;
    localparam int FIFO_LEVEL_BITS = 4;
    localparam int FIFO_PTR_BITS   = $clog2(FIFO_DEPTH);

endpackage

//--- src/mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Memory controller top: bus control, RAMs, I/O and sound FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_top (
    input  logic                                clock,
    input  logic                                reset,
    // CPU bus
    input  mem_pkg::word_t                      bus_addr,
    input  mem_pkg::word_t                      bus_wdata,
    input  mem_pkg::mem_size_t                  bus_size,
    input  logic                                bus_write,
    output mem_pkg::word_t                      bus_rdata,
    output logic                                bus_pause,
    // Graphics palette reads
    input  mem_pkg::word_t                      gfx_pal_bg_addr,
    input  mem_pkg::word_t                      gfx_pal_obj_addr,
    output mem_pkg::word_t                      gfx_pal_bg_data,
    output mem_pkg::word_t                      gfx_pal_obj_data,
    // Side inputs and outputs
    input  logic [15:0]                         buttons,
    input  logic [15:0]                         reg_if,
    output logic [15:0]                         int_acks,
    input  logic                                fifo_re,
    input  logic                                fifo_clr,
    output mem_pkg::word_t                      fifo_val,
    output logic [mem_pkg::FIFO_LEVEL_BITS-1:0] fifo_level
);

    logic fifo_push;

    mem_bus_if mem_bus ();

    bus_control i_bus_control (
        .clock     (clock),
        .reset     (reset),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_size  (bus_size),
        .bus_write (bus_write),
        .bus_pause (bus_pause),
        .bus_rdata (bus_rdata),
        .mem       (mem_bus.ctrl)
    );

    work_ram i_work_ram (
        .clock (clock),
        .mem   (mem_bus.work)
    );

    palette_ram i_palette_ram (
        .clock        (clock),
        .mem          (mem_bus.pal),
        .gfx_bg_addr  (gfx_pal_bg_addr),
        .gfx_obj_addr (gfx_pal_obj_addr),
        .gfx_bg_data  (gfx_pal_bg_data),
        .gfx_obj_data (gfx_pal_obj_data)
    );

    io_regs i_io_regs (
        .clock     (clock),
        .reset     (reset),
        .mem       (mem_bus.io),
        .buttons   (buttons),
        .reg_if    (reg_if),
        .int_acks  (int_acks),
        .fifo_push (fifo_push),
        .fifo_head (fifo_val)
    );

    // Samples come straight from the bus write data
    sound_fifo i_sound_fifo (
        .clock (clock),
        .reset (reset),
        .push  (fifo_push),
        .pop   (fifo_re),
        .clear (fifo_clr),
        .din   (mem_bus.wdata),
        .dout  (fifo_val),
        .level (fifo_level)
    );

endmodule

//--- src/palette_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Palette RAM: background and object banks, bus and graphics ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module palette_ram (
    input  logic           clock,
    mem_bus_if.pal         mem,
    input  mem_pkg::word_t gfx_bg_addr,
    input  mem_pkg::word_t gfx_obj_addr,
    output mem_pkg::word_t gfx_bg_data,
    output mem_pkg::word_t gfx_obj_data
);
    import mem_pkg::*;

    // Bank 0 is background, bank 1 is object
    word_t                     ram [2][2**PAL_WORDS_LOG2];
    lanes_t                    we_bank [2];
    logic [PAL_WORDS_LOG2-1:0] bus_idx;
    logic [PAL_WORDS_LOG2-1:0] gfx_idx [2];
    word_t                     bus_rd [2];
    word_t                     gfx_rd [2];

    assign bus_idx    = mem.mem_addr[PAL_WORDS_LOG2+1:2];
    assign gfx_idx[0] = gfx_bg_addr[PAL_WORDS_LOG2+1:2];
    assign gfx_idx[1] = gfx_obj_addr[PAL_WORDS_LOG2+1:2];

    assign we_bank[0] = mem.mem_addr[PAL_BANK_BIT] ? '0 : mem.we_pal;
    assign we_bank[1] = mem.mem_addr[PAL_BANK_BIT] ? mem.we_pal : '0;

    always_ff @(posedge clock) begin
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 4; i++) begin
                if (we_bank[b][i]) begin
                    ram[b][bus_idx][8*i +: 8] <= mem.wdata[8*i +: 8];
                end
            end
            bus_rd[b] <= ram[b][bus_idx];
            gfx_rd[b] <= ram[b][gfx_idx[b]];
        end
    end

    // Bank pick from the address of the previous cycle
    assign mem.rd_pal   = mem.addr_lat[PAL_BANK_BIT] ? bus_rd[1] : bus_rd[0];
    assign gfx_bg_data  = gfx_rd[0];
    assign gfx_obj_data = gfx_rd[1];

endmodule

//--- src/sound_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sound sample FIFO with level count and clear
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sound_fifo (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                push,
    input  logic                                pop,
    input  logic                                clear,
    input  mem_pkg::word_t                      din,
    output mem_pkg::word_t                      dout,
    output logic [mem_pkg::FIFO_LEVEL_BITS-1:0] level
);
    import mem_pkg::*;

    word_t                    ram [FIFO_DEPTH];
    logic [FIFO_PTR_BITS-1:0] wr_ptr;
    logic [FIFO_PTR_BITS-1:0] rd_ptr;
    logic                     do_push;
    logic                     do_pop;

    // Push when full and pop when empty are dropped
    assign do_push = push && (level != FIFO_LEVEL_BITS'(FIFO_DEPTH));
    assign do_pop  = pop && (level != '0);
    assign dout    = ram[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_push) begin
            ram[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the level alone
            if (do_push && !do_pop) begin
                level <= level + 1'b1;
            end else if (do_pop && !do_push) begin
                level <= level - 1'b1;
            end
        end
    end

    a_level_bound: assert property (@(posedge clock) disable iff (reset)
        level <= FIFO_LEVEL_BITS'(FIFO_DEPTH));

endmodule

//--- src/work_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal work RAM, single port with byte lanes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module work_ram (
    input  logic    clock,
    mem_bus_if.work mem
);
    import mem_pkg::*;

    word_t                      ram [2**WORK_WORDS_LOG2];
    logic [WORK_WORDS_LOG2-1:0] idx;

    // Word address, the two byte bits drop out
    assign idx = mem.mem_addr[WORK_WORDS_LOG2+1:2];

    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (mem.we_work[i]) begin
                ram[idx][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
        end
        // Read returns the old word on a same-address write
        mem.rd_work <= ram[idx];
    end

endmodule
